// File: list.f
logic/fetch_pkg.sv
logic/icache.sv
logic/stage_fetch.sv
logic/branch_predictor.sv
logic/fetch_queue.sv
logic/fetch_top.sv
tests/fetch_tb.sv

// File: logic/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int unsigned PHT_ENTRIES = 64,
    parameter int unsigned BTB_ENTRIES = 16
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           req_valid_i,
    input  fetch_pkg::addr_t               req_pc_i,
    output logic                           taken_o,
    output fetch_pkg::addr_t               target_o,
    output logic [fetch_pkg::GHR_BITS-1:0] ghr_o,
    input  fetch_pkg::resolve_t            resolve_i
);

    localparam int unsigned PHT_BITS = $clog2(PHT_ENTRIES);
    localparam int unsigned BTB_BITS = (BTB_ENTRIES > 1) ? $clog2(BTB_ENTRIES) : 1;
    localparam int unsigned TAG_BITS = 30 - BTB_BITS;
    localparam int unsigned GHR_BITS = fetch_pkg::GHR_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        fetch_pkg::addr_t    target;
    } btb_entry_t;

    logic [1:0]           pht_q [PHT_ENTRIES];
    logic [BTB_ENTRIES-1:0] btb_valid_q;
    btb_entry_t           btb_q [BTB_ENTRIES];
    logic [GHR_BITS-1:0]  ghr_q;
    logic [PHT_BITS-1:0]  req_idx;
    logic [PHT_BITS-1:0]  upd_idx;
    logic [BTB_BITS-1:0]  req_slot;
    logic [BTB_BITS-1:0]  upd_slot;
    logic                 btb_hit;
    logic [1:0]           upd_ctr;

    function automatic logic [PHT_BITS-1:0] pht_index(input fetch_pkg::addr_t pc,
                                                      input logic [GHR_BITS-1:0] ghr);
        return pc[2 +: PHT_BITS] ^ PHT_BITS'(ghr);
    endfunction

    function automatic logic [BTB_BITS-1:0] btb_slot(input fetch_pkg::addr_t pc);
        return pc[2 +: BTB_BITS];
    endfunction

    function automatic logic [TAG_BITS-1:0] btb_tag(input fetch_pkg::addr_t pc);
        return pc[31 -: TAG_BITS];
    endfunction

    always_comb begin
        req_idx  = pht_index(req_pc_i, ghr_q);
        req_slot = btb_slot(req_pc_i);
        btb_hit  = btb_valid_q[req_slot] && (btb_q[req_slot].tag == btb_tag(req_pc_i));
        taken_o  = req_valid_i && pht_q[req_idx][1] && btb_hit;  // Counter 2 or 3.
        target_o = taken_o ? btb_q[req_slot].target : '0;
    end

    assign ghr_o = ghr_q;

    // Saturating move toward the resolved outcome.
    always_comb begin
        upd_idx  = pht_index(resolve_i.pc, ghr_q);
        upd_slot = btb_slot(resolve_i.pc);
        upd_ctr  = pht_q[upd_idx];
        if (resolve_i.taken && upd_ctr != 2'd3) begin
            upd_ctr = upd_ctr + 2'd1;
        end else if (!resolve_i.taken && upd_ctr != 2'd0) begin
            upd_ctr = upd_ctr - 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b01;  // Weakly not-taken.
            end
            btb_valid_q <= '0;
            ghr_q       <= '0;
        end else if (resolve_i.valid) begin
            pht_q[upd_idx] <= upd_ctr;
            if (resolve_i.taken) begin
                btb_valid_q[upd_slot] <= 1'b1;
            end
            ghr_q <= {ghr_q[GHR_BITS-2:0], resolve_i.taken};
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_i.valid && resolve_i.taken) begin
            btb_q[upd_slot].tag    <= btb_tag(resolve_i.pc);
            btb_q[upd_slot].target <= resolve_i.target;
        end
    end

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

    localparam int unsigned GHR_BITS = 6;

    typedef logic [31:0] addr_t;

    // RV32 major opcodes seen by fetch.
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_ALU    = 7'b0110011,
        OP_LOAD   = 7'b0000011
    } opcode_e;

    typedef enum logic {
        REFILL_IDLE,
        REFILL_WAIT
    } refill_state_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
    } cache_lane_t;

    typedef struct packed {
        addr_t                pc;
        logic [31:0]          inst;
        logic                 is_branch;
        logic                 pred_taken;
        addr_t                pred_target;
        logic [GHR_BITS-1:0]  ghr_snapshot;  // History used for this prediction.
    } fetch_entry_t;

    // Branch outcome from execute.
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } resolve_t;

endpackage

// File: logic/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int unsigned FETCH_WIDTH = 2,
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t bundle_i [FETCH_WIDTH],
    output logic                    full_o,
    input  logic                    pop_i,
    output logic                    out_valid_o,
    output fetch_pkg::fetch_entry_t bundle_o [FETCH_WIDTH]
);

    localparam int unsigned PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    fetch_pkg::fetch_entry_t slot_q [QUEUE_DEPTH][FETCH_WIDTH];
    logic [PTR_BITS-1:0]     rd_ptr_q;
    logic [PTR_BITS-1:0]     wr_ptr_q;
    logic [CNT_BITS-1:0]     count_q;
    logic                    do_push;
    logic                    do_pop;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o      = (count_q == CNT_BITS'(QUEUE_DEPTH));
    assign out_valid_o = (count_q != '0);
    assign do_push     = push_i & ~full_o;
    assign do_pop      = pop_i & out_valid_o;
    assign bundle_o    = slot_q[rd_ptr_q];

    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither.
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            slot_q[wr_ptr_q] <= bundle_i;
        end
    end

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int unsigned FETCH_WIDTH   = 2,
    parameter int unsigned CACHE_LINES   = 16,
    parameter int unsigned PHT_ENTRIES   = 64,
    parameter int unsigned BTB_ENTRIES   = 16,
    parameter int unsigned QUEUE_DEPTH   = 4,
    parameter int unsigned REFILL_CYCLES = 3
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    fetch_enable_i,
    input  logic                    mem_we_i,
    input  fetch_pkg::addr_t        mem_addr_i,
    input  logic [31:0]             mem_data_i,
    input  logic                    redirect_valid_i,
    input  fetch_pkg::addr_t        redirect_pc_i,
    input  fetch_pkg::resolve_t     resolve_i,
    input  logic                    pop_i,
    output logic                    out_valid_o,
    output fetch_pkg::fetch_entry_t bundle_o [FETCH_WIDTH],
    output logic                    fetch_stall_o
);

    fetch_pkg::addr_t               lane_addr [FETCH_WIDTH];
    fetch_pkg::cache_lane_t         lane      [FETCH_WIDTH];
    fetch_pkg::fetch_entry_t        bundle    [FETCH_WIDTH];
    logic                           bundle_valid;
    logic                           queue_full;
    logic                           bp_req_valid;
    fetch_pkg::addr_t               bp_req_pc;
    logic                           bp_taken;
    fetch_pkg::addr_t               bp_target;
    logic [fetch_pkg::GHR_BITS-1:0] bp_ghr;

    icache #(
        .FETCH_WIDTH  (FETCH_WIDTH),
        .CACHE_LINES  (CACHE_LINES),
        .REFILL_CYCLES(REFILL_CYCLES)
    ) u_icache (
        .clock      (clock),
        .reset      (reset),
        .lane_addr_i(lane_addr),
        .lane_o     (lane),
        .mem_we_i   (mem_we_i),
        .mem_addr_i (mem_addr_i),
        .mem_data_i (mem_data_i)
    );

    stage_fetch #(
        .FETCH_WIDTH(FETCH_WIDTH)
    ) u_stage_fetch (
        .clock           (clock),
        .reset           (reset),
        .lane_addr_o     (lane_addr),
        .lane_i          (lane),
        .bp_req_valid_o  (bp_req_valid),
        .bp_req_pc_o     (bp_req_pc),
        .bp_req_used_o   (),  // Gshare here needs no commit strobe.
        .bp_taken_i      (bp_taken),
        .bp_target_i     (bp_target),
        .bp_ghr_i        (bp_ghr),
        .queue_full_i    (queue_full),
        .bundle_valid_o  (bundle_valid),
        .bundle_o        (bundle),
        .redirect_valid_i(redirect_valid_i),
        .redirect_pc_i   (redirect_pc_i),
        .fetch_enable_i  (fetch_enable_i),
        .fetch_stall_o   (fetch_stall_o)
    );

    branch_predictor #(
        .PHT_ENTRIES(PHT_ENTRIES),
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_branch_predictor (
        .clock      (clock),
        .reset      (reset),
        .req_valid_i(bp_req_valid),
        .req_pc_i   (bp_req_pc),
        .taken_o    (bp_taken),
        .target_o   (bp_target),
        .ghr_o      (bp_ghr),
        .resolve_i  (resolve_i)
    );

    fetch_queue #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_fetch_queue (
        .clock      (clock),
        .reset      (reset),
        .flush_i    (redirect_valid_i),  // Redirect drops queued bundles.
        .push_i     (bundle_valid),
        .bundle_i   (bundle),
        .full_o     (queue_full),
        .pop_i      (pop_i),
        .out_valid_o(out_valid_o),
        .bundle_o   (bundle_o)
    );

endmodule

// File: logic/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int unsigned FETCH_WIDTH   = 2,
    parameter int unsigned CACHE_LINES   = 16,
    parameter int unsigned REFILL_CYCLES = 3
) (
    input  logic                   clock,
    input  logic                   reset,
    input  fetch_pkg::addr_t       lane_addr_i [FETCH_WIDTH],
    output fetch_pkg::cache_lane_t lane_o      [FETCH_WIDTH],
    input  logic                   mem_we_i,
    input  fetch_pkg::addr_t       mem_addr_i,
    input  logic [31:0]            mem_data_i
);

    localparam int unsigned IDX_BITS  = (CACHE_LINES > 1) ? $clog2(CACHE_LINES) : 1;
    localparam int unsigned TAG_BITS  = 30 - IDX_BITS;
    localparam int unsigned MEM_WORDS = 1024;
    localparam int unsigned MEM_BITS  = $clog2(MEM_WORDS);
    localparam int unsigned CNT_BITS  = $clog2(REFILL_CYCLES + 1);

    logic [CACHE_LINES-1:0]   valid_q;
    logic [TAG_BITS-1:0]      tag_q  [CACHE_LINES];
    logic [31:0]              data_q [CACHE_LINES];
    logic [31:0]              mem_q  [MEM_WORDS];
    fetch_pkg::refill_state_e state_q;
    logic [CNT_BITS-1:0]      count_q;
    fetch_pkg::addr_t         fill_addr_q;
    fetch_pkg::addr_t         miss_addr;
    logic                     miss_found;
    logic                     fill_done;

    function automatic logic [IDX_BITS-1:0] line_idx(input fetch_pkg::addr_t addr);
        return addr[2 +: IDX_BITS];
    endfunction

    function automatic logic [TAG_BITS-1:0] line_tag(input fetch_pkg::addr_t addr);
        return addr[31 -: TAG_BITS];
    endfunction

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_o[i].valid = valid_q[line_idx(lane_addr_i[i])] &&
                              (tag_q[line_idx(lane_addr_i[i])] == line_tag(lane_addr_i[i]));
            lane_o[i].inst  = data_q[line_idx(lane_addr_i[i])];
        end
    end

    // Lowest missing lane is refilled first.
    always_comb begin
        miss_found = 1'b0;
        miss_addr  = '0;
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (!lane_o[i].valid) begin
                miss_found = 1'b1;
                miss_addr  = lane_addr_i[i];
            end
        end
    end

    assign fill_done = (state_q == fetch_pkg::REFILL_WAIT) &&
                       (count_q == CNT_BITS'(REFILL_CYCLES - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= fetch_pkg::REFILL_IDLE;
            count_q <= '0;
            valid_q <= '0;
        end else begin
            case (state_q)
                fetch_pkg::REFILL_IDLE: begin
                    if (miss_found) begin
                        state_q <= fetch_pkg::REFILL_WAIT;
                        count_q <= '0;
                    end
                end
                fetch_pkg::REFILL_WAIT: begin
                    if (fill_done) begin
                        state_q <= fetch_pkg::REFILL_IDLE;
                    end else begin
                        count_q <= count_q + 1'b1;  // Backing memory latency.
                    end
                end
                default: state_q <= fetch_pkg::REFILL_IDLE;
            endcase
            if (fill_done) begin
                valid_q[line_idx(fill_addr_q)] <= 1'b1;
            end
            if (mem_we_i) begin
                valid_q[line_idx(mem_addr_i)] <= 1'b0;  // Write beats a same-cycle fill.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == fetch_pkg::REFILL_IDLE && miss_found) begin
            fill_addr_q <= miss_addr;
        end
        if (fill_done) begin
            tag_q[line_idx(fill_addr_q)]  <= line_tag(fill_addr_q);
            data_q[line_idx(fill_addr_q)] <= mem_q[fill_addr_q[2 +: MEM_BITS]];
        end
        if (mem_we_i) begin
            mem_q[mem_addr_i[2 +: MEM_BITS]] <= mem_data_i;
        end
    end

endmodule

// File: logic/stage_fetch.sv
`timescale 1ns/1ps

module stage_fetch #(
    parameter int unsigned FETCH_WIDTH = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    output fetch_pkg::addr_t              lane_addr_o [FETCH_WIDTH],
    input  fetch_pkg::cache_lane_t        lane_i      [FETCH_WIDTH],
    output logic                          bp_req_valid_o,
    output fetch_pkg::addr_t              bp_req_pc_o,
    output logic                          bp_req_used_o,
    input  logic                          bp_taken_i,
    input  fetch_pkg::addr_t              bp_target_i,
    input  logic [fetch_pkg::GHR_BITS-1:0] bp_ghr_i,
    input  logic                          queue_full_i,
    output logic                          bundle_valid_o,
    output fetch_pkg::fetch_entry_t       bundle_o    [FETCH_WIDTH],
    input  logic                          redirect_valid_i,
    input  fetch_pkg::addr_t              redirect_pc_i,
    input  logic                          fetch_enable_i,
    output logic                          fetch_stall_o
);

    localparam int unsigned LANE_BITS = (FETCH_WIDTH > 1) ? $clog2(FETCH_WIDTH) : 1;
    localparam fetch_pkg::addr_t BUNDLE_BYTES = fetch_pkg::addr_t'(4 * FETCH_WIDTH);

    fetch_pkg::addr_t   pc_q;
    fetch_pkg::addr_t   pc_d;
    fetch_pkg::addr_t   lane_pc [FETCH_WIDTH];
    fetch_pkg::opcode_e lane_op [FETCH_WIDTH];
    logic               lanes_ready;
    logic               found_branch;
    logic [LANE_BITS-1:0] branch_lane;
    logic               take_target;

    always_comb begin
        lanes_ready = 1'b1;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_pc[i]     = pc_q + fetch_pkg::addr_t'(4 * i);
            lane_addr_o[i] = lane_pc[i];
            lane_op[i]     = fetch_pkg::opcode_e'(lane_i[i].inst[6:0]);
            lanes_ready    = lanes_ready & lane_i[i].valid;
        end
    end

    // Scan from the top so the lowest branch lane wins.
    always_comb begin
        found_branch = 1'b0;
        branch_lane  = '0;
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (lane_i[i].valid && lane_op[i] == fetch_pkg::OP_BRANCH) begin
                found_branch = 1'b1;
                branch_lane  = LANE_BITS'(i);
            end
        end
    end

    assign fetch_stall_o  = ~lanes_ready | queue_full_i;
    assign bundle_valid_o = fetch_enable_i & lanes_ready & ~queue_full_i & ~redirect_valid_i;

    assign bp_req_valid_o = fetch_enable_i & found_branch;
    assign bp_req_pc_o    = found_branch ? lane_pc[branch_lane] : '0;
    assign bp_req_used_o  = bundle_valid_o & found_branch;
    assign take_target    = bundle_valid_o & found_branch & bp_taken_i;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            bundle_o[i].pc           = lane_pc[i];
            bundle_o[i].inst         = lane_i[i].inst;
            bundle_o[i].is_branch    = 1'b0;
            bundle_o[i].pred_taken   = 1'b0;
            bundle_o[i].pred_target  = '0;
            bundle_o[i].ghr_snapshot = '0;
        end
        if (found_branch) begin
            bundle_o[branch_lane].is_branch    = 1'b1;
            bundle_o[branch_lane].pred_taken   = bp_taken_i;
            bundle_o[branch_lane].pred_target  = bp_target_i;
            bundle_o[branch_lane].ghr_snapshot = bp_ghr_i;
        end
    end

    always_comb begin
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (take_target) begin
            pc_d = bp_target_i;  // Predicted taken.
        end else if (bundle_valid_o) begin
            pc_d = pc_q + BUNDLE_BYTES;
        end else begin
            pc_d = pc_q;  // Blocked or disabled.
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_d;
        end
    end

endmodule

// File: tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int unsigned FETCH_WIDTH   = 2;
    localparam int unsigned CACHE_LINES   = 16;
    localparam int unsigned PHT_ENTRIES   = 64;
    localparam int unsigned BTB_ENTRIES   = 16;
    localparam int unsigned QUEUE_DEPTH   = 4;
    localparam int unsigned REFILL_CYCLES = 3;
    localparam int unsigned GHR_BITS  = fetch_pkg::GHR_BITS;
    localparam int unsigned PHT_BITS  = $clog2(PHT_ENTRIES);
    localparam int unsigned BTB_BITS  = $clog2(BTB_ENTRIES);
    localparam int unsigned MEM_WORDS = 1024;
    localparam int unsigned MEM_BITS  = $clog2(MEM_WORDS);
    localparam int unsigned TIMEOUT   = 500;
    // Longer than a refill.
    localparam int unsigned MISS_RUN  = 2 * FETCH_WIDTH * (REFILL_CYCLES + 1);

    logic                    clock;
    logic                    reset;
    logic                    fetch_enable_i;
    logic                    mem_we_i;
    fetch_pkg::addr_t        mem_addr_i;
    logic [31:0]             mem_data_i;
    logic                    redirect_valid_i;
    fetch_pkg::addr_t        redirect_pc_i;
    fetch_pkg::resolve_t     resolve_i;
    logic                    pop_i;
    logic                    out_valid_o;
    fetch_pkg::fetch_entry_t bundle_o [FETCH_WIDTH];
    logic                    fetch_stall_o;

    logic [31:0]             model_mem [MEM_WORDS];
    logic [1:0]              model_pht [PHT_ENTRIES];
    logic                    model_btb_valid [BTB_ENTRIES];
    fetch_pkg::addr_t        model_btb_pc [BTB_ENTRIES];
    fetch_pkg::addr_t        model_btb_target [BTB_ENTRIES];
    logic [GHR_BITS-1:0]     model_ghr;
    fetch_pkg::addr_t        model_pc;
    fetch_pkg::fetch_entry_t exp_bundle [FETCH_WIDTH];
    integer                  seed;

    fetch_top #(
        .FETCH_WIDTH  (FETCH_WIDTH),
        .CACHE_LINES  (CACHE_LINES),
        .PHT_ENTRIES  (PHT_ENTRIES),
        .BTB_ENTRIES  (BTB_ENTRIES),
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .REFILL_CYCLES(REFILL_CYCLES)
    ) uut (
        .clock           (clock),
        .reset           (reset),
        .fetch_enable_i  (fetch_enable_i),
        .mem_we_i        (mem_we_i),
        .mem_addr_i      (mem_addr_i),
        .mem_data_i      (mem_data_i),
        .redirect_valid_i(redirect_valid_i),
        .redirect_pc_i   (redirect_pc_i),
        .resolve_i       (resolve_i),
        .pop_i           (pop_i),
        .out_valid_o     (out_valid_o),
        .bundle_o        (bundle_o),
        .fetch_stall_o   (fetch_stall_o)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ALU word built from every address bit above the byte offset.
    function automatic logic [31:0] fill_word(input fetch_pkg::addr_t addr);
        return {addr[31:7] ^ addr[26:2], fetch_pkg::OP_ALU};
    endfunction

    task automatic report_failure(input string why);
        $display("%0s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_entry(input string name, input fetch_pkg::fetch_entry_t got,
                               input fetch_pkg::fetch_entry_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %0s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_pc(input string name, input fetch_pkg::addr_t got,
                            input fetch_pkg::addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %0s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %0s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic model_resolve(input fetch_pkg::addr_t pc, input logic taken,
                                 input fetch_pkg::addr_t target);
        logic [PHT_BITS-1:0] idx;
        idx = pc[2 +: PHT_BITS] ^ PHT_BITS'(model_ghr);  // History before this shift.
        if (taken) begin
            if (model_pht[idx] != 2'd3) begin
                model_pht[idx] = model_pht[idx] + 2'd1;
            end
            model_btb_valid[pc[2 +: BTB_BITS]]  = 1'b1;
            model_btb_pc[pc[2 +: BTB_BITS]]     = pc;
            model_btb_target[pc[2 +: BTB_BITS]] = target;
        end else if (model_pht[idx] != 2'd0) begin
            model_pht[idx] = model_pht[idx] - 2'd1;
        end
        model_ghr = {model_ghr[GHR_BITS-2:0], taken};
    endtask

    task automatic build_expected();
        fetch_pkg::addr_t    pc;
        logic                found;
        logic [PHT_BITS-1:0] idx;
        logic [BTB_BITS-1:0] slot;
        found = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pc                 = model_pc + fetch_pkg::addr_t'(4 * i);
            exp_bundle[i]      = '0;
            exp_bundle[i].pc   = pc;
            exp_bundle[i].inst = model_mem[pc[2 +: MEM_BITS]];
            if (!found && exp_bundle[i].inst[6:0] == fetch_pkg::OP_BRANCH) begin
                found = 1'b1;
                idx   = pc[2 +: PHT_BITS] ^ PHT_BITS'(model_ghr);
                slot  = pc[2 +: BTB_BITS];
                exp_bundle[i].is_branch    = 1'b1;
                exp_bundle[i].pred_taken   = model_pht[idx][1] && model_btb_valid[slot] &&
                                             (model_btb_pc[slot][31:2] == pc[31:2]);
                exp_bundle[i].pred_target  = exp_bundle[i].pred_taken ?
                                             model_btb_target[slot] : '0;
                exp_bundle[i].ghr_snapshot = model_ghr;
            end
        end
    endtask

    task automatic wait_bundle();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!out_valid_o) begin
            if (cycles == TIMEOUT) begin
                report_failure($sformatf("timeout at %0t: no bundle arrived", $time));
            end
            cycles++;
            @(negedge clock);
        end
    endtask

    // A stall longer than any refill means the queue is full.
    task automatic wait_full();
        int cycles;
        int run;
        cycles = 0;
        run    = 0;
        while (run < MISS_RUN) begin
            if (cycles == TIMEOUT) begin
                report_failure($sformatf("timeout at %0t: the queue never filled up", $time));
            end
            @(negedge clock);
            run = fetch_stall_o ? run + 1 : 0;
            cycles++;
        end
    endtask

    task automatic take_bundle(input logic from_file, input fetch_pkg::addr_t file_pc,
                               input logic file_taken);
        logic             any_taken;
        fetch_pkg::addr_t next_pc;
        wait_bundle();
        build_expected();
        any_taken = 1'b0;
        next_pc   = model_pc + fetch_pkg::addr_t'(4 * FETCH_WIDTH);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            any_taken = any_taken | bundle_o[i].pred_taken;
            if (exp_bundle[i].pred_taken) begin
                next_pc = exp_bundle[i].pred_target;
            end
        end
        if (from_file) begin
            check_pc("bundle_o[0].pc", bundle_o[0].pc, file_pc);
            check_flag("pred_taken", any_taken, file_taken);
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            check_entry($sformatf("bundle_o[%0d]", i), bundle_o[i], exp_bundle[i]);
        end
        model_pc = next_pc;
        @(posedge clock);
        pop_i <= 1'b1;
        @(posedge clock);
        pop_i <= 1'b0;
    endtask

    initial begin
        logic [63:0]      cmd;
        fetch_pkg::addr_t addr;
        logic [31:0]      arg1;
        logic [31:0]      arg2;
        logic [31:0]      arg3;
        int               fd;
        int               code;
        int               ch;
        int               gap;
        seed             = 94;
        reset            = 1'b1;
        fetch_enable_i   = 1'b0;
        mem_we_i         = 1'b0;
        mem_addr_i       = '0;
        mem_data_i       = '0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        resolve_i        = '0;
        pop_i            = 1'b0;
        model_pc         = '0;
        model_ghr        = '0;
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            model_pht[i] = 2'b01;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            model_btb_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clock);
            mem_we_i     <= 1'b1;
            mem_addr_i   <= fetch_pkg::addr_t'(4 * i);
            mem_data_i   <= fill_word(fetch_pkg::addr_t'(4 * i));
            model_mem[i] = fill_word(fetch_pkg::addr_t'(4 * i));
        end
        @(posedge clock);
        mem_we_i <= 1'b0;
        fd = $fopen("tests/fetch_tests.txt", "r");
        if (fd == 0) begin
            report_failure("could not open tests/fetch_tests.txt");
        end
        code = $fscanf(fd, " %s", cmd);
        while (code == 1) begin
            case (cmd)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "W": begin
                    code = $fscanf(fd, "%h %h", addr, arg1);
                    @(posedge clock);
                    mem_we_i   <= 1'b1;
                    mem_addr_i <= addr;
                    mem_data_i <= arg1;
                    model_mem[addr[2 +: MEM_BITS]] = arg1;
                    @(posedge clock);
                    mem_we_i <= 1'b0;
                end
                "R": begin
                    code = $fscanf(fd, "%h %h %h %h", addr, arg1, arg2, arg3);
                    for (int n = 0; n < arg3; n++) begin
                        @(posedge clock);
                        resolve_i.valid  <= 1'b1;
                        resolve_i.pc     <= addr;
                        resolve_i.taken  <= arg1[0];
                        resolve_i.target <= arg2;
                        model_resolve(addr, arg1[0], arg2);
                    end
                    @(posedge clock);
                    resolve_i.valid <= 1'b0;
                end
                "D": begin
                    code = $fscanf(fd, "%h", addr);
                    @(posedge clock);
                    redirect_valid_i <= 1'b1;
                    redirect_pc_i    <= addr;
                    @(posedge clock);
                    redirect_valid_i <= 1'b0;
                    model_pc = addr;
                end
                "E": begin
                    code = $fscanf(fd, "%h", arg1);
                    @(posedge clock);
                    fetch_enable_i <= arg1[0];
                end
                "X": begin
                    code = $fscanf(fd, "%h %h", addr, arg1);
                    take_bundle(1'b1, addr, arg1[0]);
                end
                "S": begin
                    code = $fscanf(fd, "%h", arg1);
                    wait_full();
                    for (int n = 0; n < arg1; n++) begin
                        take_bundle(1'b0, '0, 1'b0);
                        if (n == 0) begin
                            // A slot is free and the stalled lanes hit.
                            @(negedge clock);
                            check_flag("fetch_stall_o", fetch_stall_o, 1'b0);
                        end
                        gap = {$random(seed)} % 4;
                        repeat (gap) @(posedge clock);
                    end
                end
                default: report_failure($sformatf("unknown command %0s in test file", cmd));
            endcase
            code = $fscanf(fd, " %s", cmd);
        end
        $fclose(fd);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: tests/fetch_tests.txt
# Hex fields. W addr data | R pc taken target count | D pc | E enable
# X first_pc pred_taken pops one bundle | S count waits for a full queue, then pops
W 00000024 00000063
W 00000040 00000863
W 00000044 00000463
E 1
X 00000000 0
X 00000008 0
X 00000010 0
X 00000018 0
X 00000020 0
X 00000028 0
X 00000030 0
X 00000038 0
X 00000040 0
E 0
R 00000024 1 00000080 7
D 00000020
E 1
X 00000020 1
X 00000080 0
S 0
D 00000100
X 00000100 0
X 00000108 0
E 0
W 00000104 0000a5b3
D 00000100
E 1
X 00000100 0
S 12
